//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_xbuf_top
FILELIST  ?= xbuf_tile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- tb_xbuf_top.sv
/*
  Testbench for the X staging path. Runs a table of tiles through xbuf_top,
  compares each row-sum vector with a software model of the tile rule and
  checks busy_o, clear and ignored start strobes along the way.
*/
`timescale 1ns/1ps

module tb_xbuf_top;

  localparam int NUM_CASES       = 8;
  localparam int CASE_CYCLES     = xbuf_pkg::W + xbuf_pkg::DEPTH + 4 * xbuf_pkg::H + 20;
  localparam int WATCHDOG_CYCLES = 16 + NUM_CASES * CASE_CYCLES;

  // Tile case kinds
  localparam int PLAIN   = 0;
  localparam int JUNK    = 1;
  localparam int CLEAR   = 2;
  localparam int RESTART = 3;

  typedef struct {
    int              width;
    int              slots;
    bit              ramp;
    int              kind;
    xbuf_pkg::sums_t exp;
  } tile_case_t;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          clear_i;
  logic                          start_i;
  logic [xbuf_pkg::WIDTH_CW-1:0] width_i;
  logic [xbuf_pkg::SLOT_CW-1:0]  slots_i;
  logic                          x_valid_i;
  xbuf_pkg::row_t                x_row_i;
  logic                          busy_o;
  logic                          result_valid_o;
  xbuf_pkg::sums_t               sums_o;

  tile_case_t     cases [NUM_CASES];
  xbuf_pkg::row_t tile_rows [NUM_CASES][xbuf_pkg::W];

  xbuf_top i_xbuf_top (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .start_i        ( start_i        ),
    .width_i        ( width_i        ),
    .slots_i        ( slots_i        ),
    .x_valid_i      ( x_valid_i      ),
    .x_row_i        ( x_row_i        ),
    .busy_o         ( busy_o         ),
    .result_valid_o ( result_valid_o ),
    .sums_o         ( sums_o         )
  );

  // Checker sits in the top level, on the wires between buffer and reducer
  bind xbuf_top xbuf_assertions i_xbuf_assertions (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .h_shift_i      ( h_shift        ),
    .block_valid_i  ( block_valid    ),
    .tile_done_i    ( tile_done      ),
    .result_valid_i ( result_valid_o ),
    .busy_i         ( busy_o         )
  );

  always #10 clk_i = ~clk_i;

  task automatic check_sums(input string name, input xbuf_pkg::sums_t exp_v,
                            input xbuf_pkg::sums_t act_v);
    if (act_v !== exp_v) begin
      $display("error at %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
      $display("SOME TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_level(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("error at %0t: %s expected %b actual %b", $time, name, exp_v, act_v);
      $display("SOME TESTS FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic xbuf_pkg::row_t junk_row();
    xbuf_pkg::row_t row;
    int             c;
    for (c = 0; c < xbuf_pkg::DEPTH; c++) begin
      row[c] = xbuf_pkg::elem_t'($urandom);
    end
    return row;
  endfunction

  // Fills one table entry and its expected sums from the tile rule
  task automatic add_case(input int idx, input int width, input int slots,
                          input bit ramp, input int kind);
    int              r;
    int              c;
    int              sum;
    xbuf_pkg::elem_t v;
    cases[idx].width = width;
    cases[idx].slots = slots;
    cases[idx].ramp  = ramp;
    cases[idx].kind  = kind;
    for (r = 0; r < xbuf_pkg::W; r++) begin
      for (c = 0; c < xbuf_pkg::DEPTH; c++) begin
        tile_rows[idx][r][c] = cases[idx].ramp ?
                               xbuf_pkg::elem_t'(idx * 64 + r * 16 + c + 1) :
                               xbuf_pkg::elem_t'($urandom);
      end
    end
    // Only live rows and live columns add up, everything else reads as zero
    for (r = 0; r < xbuf_pkg::W; r++) begin
      sum = 0;
      for (c = 0; c < slots && r < width; c++) begin
        v   = tile_rows[idx][r][c];
        sum = sum + int'(v);
      end
      cases[idx].exp[r] = xbuf_pkg::acc_t'(sum);
    end
  endtask

  task automatic run_tile(input int idx);
    int r;
    int n;
    bit seen;
    @(posedge clk_i);
    start_i <= 1'b1;
    width_i <= xbuf_pkg::WIDTH_CW'(cases[idx].width);
    slots_i <= xbuf_pkg::SLOT_CW'(cases[idx].slots);
    @(negedge clk_i);
    check_level("busy_o", 1'b0, busy_o);
    for (r = 0; r < cases[idx].width; r++) begin
      @(posedge clk_i);
      start_i   <= 1'b0;
      x_valid_i <= 1'b1;
      x_row_i   <= tile_rows[idx][r];
      @(negedge clk_i);
      check_level("busy_o", 1'b1, busy_o);
    end
    // These beats land in the computing phase and must be dropped
    for (n = 0; n < 3 && cases[idx].kind == JUNK; n++) begin
      @(posedge clk_i);
      x_row_i <= junk_row();
    end
    @(posedge clk_i);
    x_valid_i <= 1'b0;
    if (cases[idx].kind == RESTART) begin
      start_i <= 1'b1;
      width_i <= xbuf_pkg::WIDTH_CW'(1);
      slots_i <= xbuf_pkg::SLOT_CW'(1);
    end
    @(posedge clk_i);
    start_i <= 1'b0;
    if (cases[idx].kind == CLEAR) begin
      repeat (3) @(posedge clk_i);
      clear_i <= 1'b1;
      @(posedge clk_i);
      clear_i <= 1'b0;
      @(negedge clk_i);
      check_level("busy_o", 1'b0, busy_o);
      // Aborted tile, no result strobe may follow
      for (n = 0; n < 30; n++) begin
        @(negedge clk_i);
        check_level("result_valid_o", 1'b0, result_valid_o);
        check_level("busy_o", 1'b0, busy_o);
      end
    end else begin
      seen = 1'b0;
      for (n = 0; n < CASE_CYCLES && !seen; n++) begin
        @(negedge clk_i);
        if (result_valid_o) begin
          seen = 1'b1;
        end else begin
          check_level("busy_o", 1'b1, busy_o);
        end
      end
      if (!seen) begin
        $display("error: case %0d gave no result within %0d cycles", idx, CASE_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Missing result strobe");
      end else begin
        check_sums("sums_o", cases[idx].exp, sums_o);
        // busy_o drops in the same cycle as the result strobe
        check_level("busy_o", 1'b0, busy_o);
        @(negedge clk_i);
        check_level("result_valid_o", 1'b0, result_valid_o);
      end
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("error: timeout, the tile sequence did not end within %0d cycles",
             WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int unsigned seed;
    int          i;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    start_i   = 1'b0;
    width_i   = '0;
    slots_i   = '0;
    x_valid_i = 1'b0;
    x_row_i   = '0;
    seed      = $urandom(96);

    add_case(0, 4, 16, 1'b1, PLAIN);
    add_case(1, 3, 10, 1'b1, PLAIN);
    add_case(2, 1, 5,  1'b0, PLAIN);
    add_case(3, 4, 7,  1'b0, JUNK);
    add_case(4, 2, 16, 1'b0, JUNK);
    add_case(5, 4, 13, 1'b0, CLEAR);
    add_case(6, 3, 3,  1'b0, PLAIN);
    add_case(7, 4, 9,  1'b1, RESTART);

    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_level("busy_o", 1'b0, busy_o);
    check_level("result_valid_o", 1'b0, result_valid_o);

    for (i = 0; i < NUM_CASES; i++) begin
      run_tile(i);
    end

    @(negedge clk_i);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- x_buffer.sv
/*
  X buffer. Gathers the pad rows after tile_go_i, then walks the pad column by
  column into the free half of a two-half block store. The reducer drains the
  other half through h_shift_i. Dead rows and padded columns are written as zero.
*/
`timescale 1ns/1ps

module x_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          load_i,
  input  logic [xbuf_pkg::ROW_AW-1:0]   load_row_i,
  input  xbuf_pkg::row_t                load_data_i,
  input  logic [xbuf_pkg::WIDTH_CW-1:0] cfg_width_i,
  input  logic [xbuf_pkg::SLOT_CW-1:0]  cfg_slots_i,
  input  logic                          tile_go_i,
  input  logic                          h_shift_i,
  output logic                          block_valid_o,
  output xbuf_pkg::block_t              block_o,
  output logic                          tile_last_o,
  output logic                          tile_done_o
);

  typedef enum logic [1:0] {IDLE, FAST_FILL, WAIT_FREE, DRAIN_LAST} xbuf_state_e;

  xbuf_state_e state_q, state_d;

  // Pad gather
  logic [xbuf_pkg::WIDTH_CW-1:0]    g_cnt_q;
  logic                             pad_re;
  logic                             cap_q;
  logic [xbuf_pkg::ROW_AW-1:0]      cap_row_q;
  xbuf_pkg::row_t                   pad_rdata;
  xbuf_pkg::row_t [xbuf_pkg::W-1:0] pad_img_q;
  logic                             gathered;

  // Column walk
  logic [xbuf_pkg::SLOT_CW:0]   slots_up;
  logic [xbuf_pkg::SLOT_CW-1:0] tot_cols;
  logic [xbuf_pkg::SLOT_CW-1:0] col_ptr_q;
  logic [xbuf_pkg::SLOT_CW-1:0] rd_cnt_q;
  xbuf_pkg::col_t               col_data;

  // Block store halves
  logic                        buf_we;
  logic                        buf_re;
  logic [xbuf_pkg::BLK_AW-1:0] wr_col_q;
  logic [xbuf_pkg::BLK_AW-1:0] rd_col_q, rd_col_d;
  logic                        wr_half_q;
  logic                        rd_half_q, rd_half_d;
  logic [1:0]                  full_q, full_d;
  logic                        wr_done;
  logic                        rd_free;
  xbuf_pkg::col_t              buf_rdata;

  // Column total rounded up to whole blocks
  assign slots_up = {1'b0, cfg_slots_i} + (xbuf_pkg::SLOT_CW + 1)'(xbuf_pkg::H - 1);
  assign tot_cols = {slots_up[xbuf_pkg::SLOT_CW-1:xbuf_pkg::BLK_AW], {xbuf_pkg::BLK_AW{1'b0}}};

  // One pad row per cycle, captured a cycle later
  assign pad_re   = (state_q == FAST_FILL) && (g_cnt_q != xbuf_pkg::W_CNT);
  assign gathered = (g_cnt_q == xbuf_pkg::W_CNT) && !cap_q;

  x_elem_array #(
    .word_t  ( xbuf_pkg::row_t ),
    .ENTRIES ( xbuf_pkg::W     )
  ) i_pad (
    .clk_i   ( clk_i                             ),
    .rst_ni  ( rst_ni                            ),
    .we_i    ( load_i                            ),
    .waddr_i ( load_row_i                        ),
    .wdata_i ( load_data_i                       ),
    .re_i    ( pad_re                            ),
    .raddr_i ( g_cnt_q[xbuf_pkg::ROW_AW-1:0]     ),
    .rdata_o ( pad_rdata                         )
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      g_cnt_q   <= '0;
      cap_q     <= 1'b0;
      cap_row_q <= '0;
    end else if (clear_i || tile_go_i) begin
      g_cnt_q <= '0;
      cap_q   <= 1'b0;
    end else begin
      cap_q     <= pad_re;
      cap_row_q <= g_cnt_q[xbuf_pkg::ROW_AW-1:0];
      if (pad_re) begin
        g_cnt_q <= g_cnt_q + 1'b1;
      end
    end
  end

  // Rows at or beyond width are zeroed on capture
  always_ff @(posedge clk_i) begin
    if (cap_q) begin
      pad_img_q[cap_row_q] <= (xbuf_pkg::WIDTH_CW'(cap_row_q) < cfg_width_i) ? pad_rdata : '0;
    end
  end

  // Column at the walk pointer, zero past slots
  always_comb begin
    for (int r = 0; r < xbuf_pkg::W; r++) begin
      col_data[r] = (col_ptr_q < cfg_slots_i) ?
                    pad_img_q[r][col_ptr_q[xbuf_pkg::COL_AW-1:0]] : '0;
    end
  end

  assign buf_we  = (state_q == FAST_FILL) && gathered;
  assign wr_done = buf_we && (wr_col_q == xbuf_pkg::LAST_COL);
  assign rd_free = h_shift_i && (rd_col_q == xbuf_pkg::LAST_COL);

  always_comb begin
    full_d = full_q;
    if (rd_free) begin
      full_d[rd_half_q] = 1'b0;
    end
    if (wr_done) begin
      full_d[wr_half_q] = 1'b1;
    end
  end

  // Read address runs one step ahead so rdata already holds the next column
  assign rd_col_d  = h_shift_i ? rd_col_q + 1'b1 : rd_col_q;
  assign rd_half_d = rd_half_q ^ rd_free;
  assign buf_re    = h_shift_i || !block_valid_o;

  x_elem_array #(
    .word_t  ( xbuf_pkg::col_t  ),
    .ENTRIES ( 2 * xbuf_pkg::H  )
  ) i_blk (
    .clk_i   ( clk_i                  ),
    .rst_ni  ( rst_ni                 ),
    .we_i    ( buf_we                 ),
    .waddr_i ( {wr_half_q, wr_col_q}  ),
    .wdata_i ( col_data               ),
    .re_i    ( buf_re                 ),
    .raddr_i ( {rd_half_d, rd_col_d}  ),
    .rdata_o ( buf_rdata              )
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (tile_go_i) begin
          state_d = FAST_FILL;
        end
      end
      FAST_FILL: begin
        if (wr_done) begin
          if (col_ptr_q + 1'b1 == tot_cols) begin
            state_d = DRAIN_LAST;
          end else if (full_d[~wr_half_q]) begin
            state_d = WAIT_FREE;
          end
        end
      end
      WAIT_FREE: begin
        if (!full_q[wr_half_q]) begin
          state_d = FAST_FILL;
        end
      end
      DRAIN_LAST: begin
        if (tile_done_o) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      full_q    <= '0;
      wr_col_q  <= '0;
      wr_half_q <= 1'b0;
      rd_col_q  <= '0;
      rd_half_q <= 1'b0;
      col_ptr_q <= '0;
      rd_cnt_q  <= '0;
    end else if (clear_i) begin
      state_q   <= IDLE;
      full_q    <= '0;
      wr_col_q  <= '0;
      wr_half_q <= 1'b0;
      rd_col_q  <= '0;
      rd_half_q <= 1'b0;
      col_ptr_q <= '0;
      rd_cnt_q  <= '0;
    end else begin
      state_q   <= state_d;
      full_q    <= full_d;
      rd_col_q  <= rd_col_d;
      rd_half_q <= rd_half_d;
      if (buf_we) begin
        wr_col_q  <= wr_col_q + 1'b1;
        wr_half_q <= wr_half_q ^ wr_done;
        col_ptr_q <= col_ptr_q + 1'b1;
      end
      if (tile_go_i) begin
        col_ptr_q <= '0;
        rd_cnt_q  <= '0;
      end else if (h_shift_i) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
    end
  end

  assign block_valid_o = full_q[rd_half_q];

  // Only the column under the read pointer is live in the block
  always_comb begin
    for (int h = 0; h < xbuf_pkg::H; h++) begin
      block_o[h] = (xbuf_pkg::BLK_AW'(h) == rd_col_q) ? buf_rdata : '0;
    end
  end

  assign tile_last_o = block_valid_o &&
                       (({1'b0, rd_cnt_q} + (xbuf_pkg::SLOT_CW + 1)'(xbuf_pkg::H)) >=
                        {1'b0, tot_cols});
  assign tile_done_o = (state_q == DRAIN_LAST) && h_shift_i &&
                       (rd_cnt_q + 1'b1 == tot_cols);

endmodule

//--- x_elem_array.sv
/*
  Flop array with one write port and one registered read port.
  Used for both the pad store and the double-buffered block store.
*/
`timescale 1ns/1ps

module x_elem_array #(
  parameter type         word_t  = logic,
  parameter int unsigned ENTRIES = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       we_i,
  input  logic [$clog2(ENTRIES)-1:0] waddr_i,
  input  word_t                      wdata_i,
  input  logic                       re_i,
  input  logic [$clog2(ENTRIES)-1:0] raddr_i,
  output word_t                      rdata_o
);

  word_t mem_q [ENTRIES];
  word_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // A write and a read of the same entry in one cycle returns the old word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (re_i) begin
      rdata_q <= mem_q[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- x_row_reducer.sv
/*
  Row reduction engine. Shifts through every ready block one column per
  cycle, keeps one running sum per tile row and publishes the sums after
  the last column of the tile.
*/
`timescale 1ns/1ps

module x_row_reducer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             block_valid_i,
  input  xbuf_pkg::block_t block_i,
  input  logic             tile_last_i,
  input  logic             tile_done_i,
  output logic             h_shift_o,
  output logic             result_valid_o,
  output xbuf_pkg::sums_t  sums_o
);

  logic [xbuf_pkg::BLK_AW-1:0] col_q;
  xbuf_pkg::sums_t             acc_q, acc_d;
  xbuf_pkg::sums_t             sums_q;
  logic                        res_q;
  logic                        fin;

  // No stall, a valid block is always consumed
  assign h_shift_o = block_valid_i;
  assign fin       = tile_done_i && tile_last_i;

  always_comb begin
    acc_d = acc_q;
    if (h_shift_o) begin
      for (int r = 0; r < xbuf_pkg::W; r++) begin
        acc_d[r] = acc_q[r] + xbuf_pkg::acc_t'($signed(block_i[col_q][r]));
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      col_q <= '0;
      acc_q <= '0;
      res_q <= 1'b0;
    end else if (clear_i) begin
      col_q <= '0;
      acc_q <= '0;
      res_q <= 1'b0;
    end else begin
      res_q <= fin;
      if (h_shift_o) begin
        col_q <= col_q + 1'b1;
      end
      // Start the next tile from zero
      acc_q <= fin ? '0 : acc_d;
    end
  end

  // Final sums include the column shifted on the done cycle
  always_ff @(posedge clk_i) begin
    if (fin) begin
      sums_q <= acc_d;
    end
  end

  assign result_valid_o = res_q;
  assign sums_o         = sums_q;

endmodule

//--- x_row_streamer.sv
/*
  Tile producer. Latches the tile configuration on start_i, turns accepted
  beats into pad row writes and strobes tile_go_o once width rows are in.
*/
`timescale 1ns/1ps

module x_row_streamer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  logic [xbuf_pkg::WIDTH_CW-1:0] width_i,
  input  logic [xbuf_pkg::SLOT_CW-1:0]  slots_i,
  input  logic                          x_valid_i,
  input  logic                          tile_done_i,
  output logic                          load_o,
  output logic [xbuf_pkg::ROW_AW-1:0]   load_row_o,
  output logic [xbuf_pkg::WIDTH_CW-1:0] cfg_width_o,
  output logic [xbuf_pkg::SLOT_CW-1:0]  cfg_slots_o,
  output logic                          tile_go_o,
  output logic                          busy_o
);

  typedef enum logic [1:0] {PH_IDLE, PH_LOAD, PH_COMPUTE} phase_e;

  phase_e                        phase_q;
  logic [xbuf_pkg::WIDTH_CW-1:0] rows_q;
  logic [xbuf_pkg::WIDTH_CW-1:0] cfg_width_q;
  logic [xbuf_pkg::SLOT_CW-1:0]  cfg_slots_q;
  logic                          tile_go_q;
  logic                          last_beat;

  // Beats outside the loading phase are dropped
  assign load_o     = (phase_q == PH_LOAD) && x_valid_i;
  assign load_row_o = rows_q[xbuf_pkg::ROW_AW-1:0];
  assign last_beat  = load_o && (rows_q + 1'b1 == cfg_width_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q     <= PH_IDLE;
      rows_q      <= '0;
      cfg_width_q <= '0;
      cfg_slots_q <= '0;
      tile_go_q   <= 1'b0;
    end else if (clear_i) begin
      phase_q   <= PH_IDLE;
      rows_q    <= '0;
      tile_go_q <= 1'b0;
    end else begin
      tile_go_q <= last_beat;
      case (phase_q)
        PH_IDLE: begin
          if (start_i) begin
            phase_q     <= PH_LOAD;
            rows_q      <= '0;
            cfg_width_q <= width_i;
            cfg_slots_q <= slots_i;
          end
        end
        PH_LOAD: begin
          if (last_beat) begin
            phase_q <= PH_COMPUTE;
          end else if (load_o) begin
            rows_q <= rows_q + 1'b1;
          end
        end
        PH_COMPUTE: begin
          // start_i is ignored until the buffer reports the final shift
          if (tile_done_i) begin
            phase_q <= PH_IDLE;
            rows_q  <= '0;
          end
        end
        default: phase_q <= PH_IDLE;
      endcase
    end
  end

  assign cfg_width_o = cfg_width_q;
  assign cfg_slots_o = cfg_slots_q;
  assign tile_go_o   = tile_go_q;
  assign busy_o      = (phase_q != PH_IDLE);

endmodule

//--- xbuf_assertions.sv
/*
  Protocol checks on the buffer to reducer handshake and on the result strobe.
  Bound into the top level, where the buffer and reducer wires meet.
*/
`timescale 1ns/1ps

module xbuf_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic h_shift_i,
  input logic block_valid_i,
  input logic tile_done_i,
  input logic result_valid_i,
  input logic busy_i
);

  // A column is only consumed out of a complete block
  a_shift_needs_block: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    h_shift_i |-> block_valid_i
  ) else $error("h_shift high without block_valid");

  // Final shift of a tile gives the result strobe one cycle later
  a_done_then_result: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    tile_done_i |=> result_valid_i
  ) else $error("tile_done not followed by result_valid");

  // Busy has already dropped when the sums come out
  a_result_not_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni || clear_i)
    result_valid_i |-> !busy_i
  ) else $error("result_valid high while busy");

endmodule

//--- xbuf_pkg.sv
/*
  Shared element type, tile geometry and count widths of the X staging path.
  RTL and testbench refer to these by scoped name.
*/
package xbuf_pkg;

  // Tile element
  localparam int unsigned ELEM_W = 16;
  typedef logic signed [ELEM_W-1:0] elem_t;

  // Tile geometry, H and DEPTH are powers of two and DEPTH is a multiple of H
  localparam int unsigned W     = 4;
  localparam int unsigned H     = 4;
  localparam int unsigned DEPTH = 16;

  // Index and count widths
  localparam int unsigned ROW_AW   = $clog2(W);
  localparam int unsigned BLK_AW   = $clog2(H);
  localparam int unsigned COL_AW   = $clog2(DEPTH);
  localparam int unsigned WIDTH_CW = $clog2(W + 1);
  localparam int unsigned SLOT_CW  = $clog2(DEPTH + 1);

  // Sized constants for counter compares
  localparam logic [BLK_AW-1:0]   LAST_COL = BLK_AW'(H - 1);
  localparam logic [WIDTH_CW-1:0] W_CNT    = WIDTH_CW'(W);

  typedef elem_t [DEPTH-1:0] row_t;
  typedef elem_t [W-1:0]     col_t;
  typedef col_t  [H-1:0]     block_t;

  // Row sums
  localparam int unsigned ACC_W = 24;
  typedef logic signed [ACC_W-1:0] acc_t;
  typedef acc_t [W-1:0]            sums_t;

endpackage

//--- xbuf_tile.f
xbuf_pkg.sv
x_elem_array.sv
x_row_streamer.sv
x_buffer.sv
x_row_reducer.sv
xbuf_top.sv
xbuf_assertions.sv
tb_xbuf_top.sv

//--- xbuf_top.sv
/*
  Top level of the X staging path. Streamer, buffer and reducer in a chain;
  one tile in per start_i, one vector of row sums out per result_valid_o.
*/
`timescale 1ns/1ps

module xbuf_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          start_i,
  input  logic [xbuf_pkg::WIDTH_CW-1:0] width_i,
  input  logic [xbuf_pkg::SLOT_CW-1:0]  slots_i,
  input  logic                          x_valid_i,
  input  xbuf_pkg::row_t                x_row_i,
  output logic                          busy_o,
  output logic                          result_valid_o,
  output xbuf_pkg::sums_t               sums_o
);

  logic                          pad_we;
  logic [xbuf_pkg::ROW_AW-1:0]   pad_waddr;
  logic [xbuf_pkg::WIDTH_CW-1:0] cfg_width;
  logic [xbuf_pkg::SLOT_CW-1:0]  cfg_slots;
  logic                          tile_go;
  logic                          block_valid;
  xbuf_pkg::block_t              block_data;
  logic                          tile_last;
  logic                          h_shift;
  logic                          tile_done;

  x_row_streamer i_streamer (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .clear_i     ( clear_i   ),
    .start_i     ( start_i   ),
    .width_i     ( width_i   ),
    .slots_i     ( slots_i   ),
    .x_valid_i   ( x_valid_i ),
    .tile_done_i ( tile_done ),
    .load_o      ( pad_we    ),
    .load_row_o  ( pad_waddr ),
    .cfg_width_o ( cfg_width ),
    .cfg_slots_o ( cfg_slots ),
    .tile_go_o   ( tile_go   ),
    .busy_o      ( busy_o    )
  );

  x_buffer i_buffer (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .load_i        ( pad_we      ),
    .load_row_i    ( pad_waddr   ),
    .load_data_i   ( x_row_i     ),
    .cfg_width_i   ( cfg_width   ),
    .cfg_slots_i   ( cfg_slots   ),
    .tile_go_i     ( tile_go     ),
    .h_shift_i     ( h_shift     ),
    .block_valid_o ( block_valid ),
    .block_o       ( block_data  ),
    .tile_last_o   ( tile_last   ),
    .tile_done_o   ( tile_done   )
  );

  x_row_reducer i_reducer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .block_valid_i  ( block_valid    ),
    .block_i        ( block_data     ),
    .tile_last_i    ( tile_last      ),
    .tile_done_i    ( tile_done      ),
    .h_shift_o      ( h_shift        ),
    .result_valid_o ( result_valid_o ),
    .sums_o         ( sums_o         )
  );

endmodule
